// File: bench/mipsExecModel.svh
// shadow copy of the register file, r0 never written
logic [31:0] shadowRegs [0:31];

////////////////////////////////////////
// instruction builders
////////////////////////////////////////
function automatic logic [31:0] buildR(input logic [5:0] fn, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] sh);
    return {opSpecial, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] buildMul(input logic [4:0] rd, input logic [4:0] rs,
                                         input logic [4:0] rt);
    return {opMul, rs, rt, rd, 5'd0, 6'b000010}; // funct ignored for mul
endfunction

function automatic logic [31:0] buildI(input logic [5:0] op, input logic [4:0] rt,
                                       input logic [4:0] rs, input logic [31:0] imm);
    return {op, rs, rt, imm[15:0]}; // only low half of imm used
endfunction

////////////////////////////////////////
// expected result, updates shadow regs
////////////////////////////////////////
function automatic execResult_t refExec(input logic [31:0] word);
    execResult_t res;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immS;
    logic [31:0] immZ;
    logic        isMem;
    res          = '0;
    res.valid    = 1'b1;
    a            = shadowRegs[word[25:21]];   // rs
    b            = shadowRegs[word[20:16]];   // rt
    immS         = {{16{word[15]}}, word[15:0]};
    immZ         = {16'h0000, word[15:0]};
    res.destAddr = word[20:16];               // rt unless r-type
    isMem        = 1'b0;
    case (word[31:26])
        opSpecial: begin
            res.destAddr = word[15:11];
            case (word[5:0])
                fnSll:   res.data = b << word[10:6];
                fnSrl:   res.data = b >> word[10:6];
                fnSlt:   res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                fnOr:    res.data = a | b;
                fnNor:   res.data = ~(a | b);
                fnXor:   res.data = a ^ b;
                fnAdd:   res.data = a + b;
                fnSub:   res.data = a - b;
                fnAnd:   res.data = a & b;
                default: res.illegal = 1'b1;
            endcase
        end
        opMul: begin
            res.destAddr = word[15:11];
            res.data     = a * b; // low word, sign does not matter
        end
        opAndi:  res.data = a & immZ;
        opAddi:  res.data = a + immS;
        opOri:   res.data = a | immZ;
        opXori:  res.data = a ^ immZ;
        opSlti:  res.data = ($signed(a) < $signed(immS)) ? 32'd1 : 32'd0;
        opLw, opLh, opLb, opSw, opSh, opSb: begin
            res.data = a + immS; // effective address only
            isMem    = 1'b1;
        end
        default: res.illegal = 1'b1;
    endcase
    res.regWrite = !res.illegal && !isMem && (res.destAddr != 5'd0);
    if (res.illegal) begin
        res.data = '0;
    end
    if (res.regWrite) begin
        shadowRegs[res.destAddr] = res.data; // program order = forwarding
    end
    return res;
endfunction

// File: bench/mipsExecTb.sv
`timescale 1ns/10ps

module mipsExecTb import mipsExecPkg::*; ();

    logic        clk;
    logic        arstN;
    logic        instrValid;
    instrWord_t  instr;
    execResult_t result;

    int cycle = 0;      // posedge count
    int errCount = 0;
    int checkCount = 0;
    execResult_t expQ[$];
    int sampleQ[$];     // posedge count when the instr went out

    logic [5:0] fnList [9] = '{fnSll, fnSrl, fnSlt, fnOr, fnNor, fnXor, fnAdd, fnSub, fnAnd};
    logic [5:0] memOps [6] = '{opLw, opLh, opLb, opSw, opSh, opSb};
    logic [5:0] badOps [4] = '{6'b000010, 6'b000100, 6'b000101, 6'b111111}; // j, beq, bne
    logic [5:0] badFns [4] = '{6'b001000, 6'b011000, 6'b100001, 6'b000011}; // jr, mult, addu, sra

    `include "mipsExecModel.svh"

    mipsExecTop dut0 (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    task automatic sendInstr(input logic [31:0] word);
        @(negedge clk);
        instrValid = 1'b1;
        instr      = word;
        expQ.push_back(refExec(word));
        sampleQ.push_back(cycle); // result due two counts later
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            instrValid = 1'b0;
            instr      = $urandom(); // junk the dut must ignore
        end
    endtask

    task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] want);
        checkCount++;
        assert (got === want) else begin
            $display("[ERROR] %s got %h expected %h", name, got, want);
            errCount++;
        end
    endtask

    ////////////////////////////////////////
    // compare process on the falling edge
    ////////////////////////////////////////
    always @(negedge clk) begin
        execResult_t want;
        if (arstN && result.valid) begin
            if (expQ.size() == 0 || sampleQ[0] + 2 > cycle) begin
                $display("result strobe at cycle %0d with no instruction waiting for it", cycle);
                errCount++;
            end else begin
                want = expQ.pop_front();
                void'(sampleQ.pop_front());
                checkField("result.illegal", result.illegal, want.illegal);
                checkField("result.regWrite", result.regWrite, want.regWrite);
                checkField("result.destAddr", result.destAddr, want.destAddr);
                checkField("result.data", result.data, want.data);
            end
        end else if (arstN && expQ.size() != 0 && sampleQ[0] + 2 <= cycle) begin
            $display("missing result strobe for instruction sampled at cycle %0d", sampleQ[0]);
            errCount++;
            void'(expQ.pop_front());
            void'(sampleQ.pop_front());
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        int          pick;
        int          waitCount;
        void'($urandom(32'h10eb_866e));
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        for (int r = 0; r < 32; r++) shadowRegs[r] = '0;

        // no strobe while reset is held
        repeat (10) begin
            @(negedge clk);
            assert (result.valid === 1'b0) else begin
                $display("result strobe seen while reset is held");
                errCount++;
            end
        end
        arstN = 1'b1;
        idleCycles(4);
        for (int n = 0; n < 6; n++) begin
            sendInstr(buildR(fnAdd, 5'd0, $urandom % 32, $urandom % 32, 5'd0)); // cleared regs
        end

        // load r1..r15 then random r-type and mul
        for (int r = 1; r < 16; r++) sendInstr(buildI(opAddi, r, 5'd0, $urandom()));
        for (int n = 0; n < 60; n++) begin
            pick = $urandom % 10;
            rd   = $urandom % 16;
            rs   = $urandom % 16;
            rt   = $urandom % 16;
            if (pick == 9) sendInstr(buildMul(rd, rs, rt));
            else sendInstr(buildR(fnList[pick], rd, rs, rt, $urandom % 32));
            if ($urandom % 4 == 0) idleCycles(1 + $urandom % 2); // gaps now and then
        end

        // immediates with bit 15 set
        for (int n = 0; n < 4; n++) begin
            sendInstr(buildI(opAddi, 16 + $urandom % 8, $urandom % 16, 32'h8000 | $urandom()));
            sendInstr(buildI(opSlti, 16 + $urandom % 8, $urandom % 16, 32'h8000 | $urandom()));
            sendInstr(buildI(opAndi, 16 + $urandom % 8, $urandom % 16, 32'h8000 | $urandom()));
            sendInstr(buildI(opOri, 16 + $urandom % 8, $urandom % 16, 32'h8000 | $urandom()));
            sendInstr(buildI(opXori, 16 + $urandom % 8, $urandom % 16, 32'h8000 | $urandom()));
        end

        // dependent chains at distance one and two
        sendInstr(buildI(opAddi, 5'd24, 5'd0, 32'd7));
        sendInstr(buildR(fnAdd, 5'd25, 5'd24, 5'd24, 5'd0));
        sendInstr(buildR(fnSub, 5'd26, 5'd25, 5'd24, 5'd0));
        for (int n = 0; n < 12; n++) begin
            sendInstr(buildR(fnAdd, 5'd27, 5'd27, 5'd26, 5'd0));
            sendInstr(buildI(opXori, 5'd26, 5'd27, $urandom()));
            sendInstr(buildMul(5'd28, 5'd27, 5'd26));
            sendInstr(buildR(fnSll, 5'd27, 5'd0, 5'd28, $urandom % 32));
        end

        // memory ops give the address and leave dest alone
        for (int n = 0; n < 12; n++) begin
            rt = 1 + $urandom % 15;
            sendInstr(buildI(memOps[n % 6], rt, 1 + $urandom % 15, $urandom()));
            sendInstr(buildR(fnOr, 5'd0, rt, 5'd0, 5'd0)); // read dest back
        end
        sendInstr(buildI(opAddi, 5'd0, 5'd1, 32'd5)); // r0 write dropped
        sendInstr(buildR(fnAdd, 5'd29, 5'd0, 5'd0, 5'd0));

        // illegal opcodes and functions
        for (int n = 0; n < 4; n++) begin
            sendInstr(buildI(badOps[n], 1 + $urandom % 31, $urandom % 32, $urandom()));
            sendInstr(buildR(badFns[n], 1 + $urandom % 31, $urandom % 32, $urandom % 32, 5'd0));
        end
        for (int r = 1; r < 32; r++) sendInstr(buildR(fnOr, 5'd0, r, 5'd0, 5'd0)); // sweep

        // drain
        idleCycles(1);
        waitCount = 0;
        while (expQ.size() != 0 && waitCount < 20) begin
            @(negedge clk);
            waitCount++;
        end
        if (expQ.size() != 0) begin
            $display("timed out with %0d results still outstanding", expQ.size());
            errCount++;
        end
        idleCycles(3);

        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: mipsExec.f
+incdir+bench
rtl/mipsExecPkg.sv
rtl/aluController.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/mipsExecTop.sv
bench/mipsExecTb.sv

// File: rtl/alu.sv
`timescale 1ns/10ps

module alu import mipsExecPkg::*; (
    input  aluOp_t      aluControl,
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    input  logic [4:0]  shamt,
    output logic [31:0] aluOut
);

    logic [63:0] product;   // full signed product
    logic        lessThan;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    assign product  = $signed(opA) * $signed(opB);
    assign lessThan = $signed(opA) < $signed(opB);

    ////////////////////////////////////////
    // op select
    ////////////////////////////////////////
    always_comb begin
        case (aluControl)
            aluAdd:  aluOut = opA + opB;      // also mem address
            aluSub:  aluOut = opA - opB;
            aluAnd:  aluOut = opA & opB;
            aluOr:   aluOut = opA | opB;
            aluNor:  aluOut = ~(opA | opB);
            aluXor:  aluOut = opA ^ opB;
            aluSll:  aluOut = opB << shamt;   // shifts work on rt
            aluSrl:  aluOut = opB >> shamt;   // logical, zero fill
            aluMul:  aluOut = product[31:0];  // low word only
            aluSlt:  aluOut = {31'd0, lessThan};
            default: aluOut = '0;             // unused codes
        endcase
    end

endmodule

// File: rtl/aluController.sv
`timescale 1ns/10ps

module aluController import mipsExecPkg::*; (
    input  logic [5:0] opCode,
    input  logic [5:0] funct,
    output aluOp_t     aluControl,
    output logic       illegal
);

    ////////////////////////////////////////
    // opcode then funct lookup
    ////////////////////////////////////////
    always_comb begin
        aluControl = aluAdd; // default so no latch
        illegal    = 1'b0;

        case (opCode)
            opSpecial: begin
                // r-type ops decoded from funct
                case (funct)
                    fnSll:   aluControl = aluSll;
                    fnSrl:   aluControl = aluSrl;
                    fnSlt:   aluControl = aluSlt;
                    fnOr:    aluControl = aluOr;
                    fnNor:   aluControl = aluNor;
                    fnXor:   aluControl = aluXor;
                    fnAdd:   aluControl = aluAdd;
                    fnSub:   aluControl = aluSub;
                    fnAnd:   aluControl = aluAnd;
                    default: illegal    = 1'b1; // unknown funct
                endcase
            end

            opMul:   aluControl = aluMul; // funct not looked at

            // immediate alu ops
            opAndi:  aluControl = aluAnd;
            opAddi:  aluControl = aluAdd;
            opOri:   aluControl = aluOr;
            opXori:  aluControl = aluXor;
            opSlti:  aluControl = aluSlt;

            // memory ops just need base + offset
            opLw:    aluControl = aluAdd;
            opLh:    aluControl = aluAdd;
            opLb:    aluControl = aluAdd;
            opSw:    aluControl = aluAdd;
            opSh:    aluControl = aluAdd;
            opSb:    aluControl = aluAdd;

            // branches and jumps not handled in this unit
            default: illegal = 1'b1;
        endcase
    end

endmodule

// File: rtl/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder import mipsExecPkg::*; (
    input  instrWord_t instr,
    output decodedOp_t decoded
);

    aluOp_t      aluCode;
    logic        badCode;   // from controller
    logic        isRType;   // special or mul
    logic        isMem;
    logic        zeroExt;   // logical immediates
    logic        isShift;
    logic [4:0]  destSel;
    logic [31:0] immExt;

    aluController aluCtrl0 (
        .opCode     (instr.r.opCode),
        .funct      (instr.r.funct),
        .aluControl (aluCode),
        .illegal    (badCode)
    );

    ////////////////////////////////////////
    // instruction class
    ////////////////////////////////////////
    assign isRType = (instr.r.opCode == opSpecial) || (instr.r.opCode == opMul);
    assign isMem   = instr.i.opCode inside {opLw, opLh, opLb, opSw, opSh, opSb};
    assign zeroExt = instr.i.opCode inside {opAndi, opOri, opXori};
    assign isShift = (instr.r.opCode == opSpecial) && (instr.r.funct inside {fnSll, fnSrl});

    // rd for r-type, rt otherwise
    assign destSel = isRType ? instr.r.rd : instr.i.rt;

    // andi/ori/xori zero extend, addi/slti/mem sign extend
    assign immExt = zeroExt ? {16'h0000, instr.i.imm}
                            : {{16{instr.i.imm[15]}}, instr.i.imm};

    ////////////////////////////////////////
    // build decoded op
    ////////////////////////////////////////
    always_comb begin
        decoded          = '0;
        decoded.aluOp    = aluCode;
        decoded.illegal  = badCode;
        decoded.destAddr = destSel;

        if (isRType) begin
            decoded.rsAddr   = instr.r.rs;
            decoded.rtAddr   = instr.r.rt;  // shifted operand for sll/srl
            decoded.shamt    = instr.r.shamt;
            decoded.useShamt = isShift;
        end else begin
            decoded.rsAddr   = instr.i.rs;  // base for mem ops
            decoded.rtAddr   = instr.i.rt;
            decoded.immValue = immExt;
            decoded.useImm   = 1'b1;
        end

        // no write for stores/loads, bad codes or r0
        decoded.regWrite = !badCode && !isMem && (destSel != 5'd0);
    end

endmodule

// File: rtl/mipsExecPkg.sv
package mipsExecPkg;

    ////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////
    localparam logic [5:0] opSpecial = 6'b000000; // r-type, op picked by funct
    localparam logic [5:0] opMul     = 6'b011100; // special2 mul
    localparam logic [5:0] opAndi    = 6'b001100;
    localparam logic [5:0] opAddi    = 6'b001000;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opXori    = 6'b001110;
    localparam logic [5:0] opSlti    = 6'b001010;
    // loads and stores only form base plus offset here
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opLh      = 6'b100001;
    localparam logic [5:0] opLb      = 6'b100000;
    localparam logic [5:0] opSw      = 6'b101011;
    localparam logic [5:0] opSh      = 6'b101001;
    localparam logic [5:0] opSb      = 6'b101000;

    ////////////////////////////////////////
    // special function field
    ////////////////////////////////////////
    localparam logic [5:0] fnSll = 6'b000000; // shifts use shamt
    localparam logic [5:0] fnSrl = 6'b000010;
    localparam logic [5:0] fnSlt = 6'b101010;
    localparam logic [5:0] fnOr  = 6'b100101;
    localparam logic [5:0] fnNor = 6'b100111;
    localparam logic [5:0] fnXor = 6'b100110;
    localparam logic [5:0] fnAdd = 6'b100000;
    localparam logic [5:0] fnSub = 6'b100010;
    localparam logic [5:0] fnAnd = 6'b100100;

    // alu control code, same numbering as the old controller
    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluNor = 4'd4,
        aluXor = 4'd5,
        aluSll = 4'd6,
        aluSrl = 4'd7,
        aluMul = 4'd8,
        aluSlt = 4'd9
    } aluOp_t;

    ////////////////////////////////////////
    // instruction word views
    ////////////////////////////////////////
    typedef struct packed {
        logic [5:0] opCode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeInstr_t;

    typedef struct packed {
        logic [5:0]  opCode;
        logic [4:0]  rs;
        logic [4:0]  rt;     // dest for i-type
        logic [15:0] imm;
    } iTypeInstr_t;

    // one word, two decodes
    typedef union packed {
        rTypeInstr_t r;
        iTypeInstr_t i;
    } instrWord_t;

    // decoder output, captured in stage 1
    typedef struct packed {
        aluOp_t      aluOp;
        logic [4:0]  rsAddr;
        logic [4:0]  rtAddr;
        logic [4:0]  destAddr;
        logic [31:0] immValue;  // already sign or zero extended
        logic        useImm;
        logic        useShamt;
        logic [4:0]  shamt;
        logic        regWrite;
        logic        illegal;
    } decodedOp_t;

    // stage 2 result, also the writeback bundle
    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic        regWrite;
        logic [4:0]  destAddr;
        logic [31:0] data;
    } execResult_t;

endpackage

// File: rtl/mipsExecTop.sv
`timescale 1ns/10ps

module mipsExecTop import mipsExecPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        instrValid,
    input  instrWord_t  instr,
    output execResult_t result
);

    decodedOp_t  decodedNow;  // current instr, comb
    logic [31:0] rfDataA;
    logic [31:0] rfDataB;
    logic [31:0] fwdA;        // rs after forwarding
    logic [31:0] fwdB;        // rt after forwarding
    logic        s1Writes;

    // stage 1 regs
    logic        s1Valid;
    decodedOp_t  s1Op;
    logic [31:0] s1RsVal;
    logic [31:0] s1RtVal;

    logic [31:0] aluOpB;
    logic [4:0]  aluShamt;
    logic [31:0] aluOut;
    execResult_t resultNext;

    instrDecoder dec0 (
        .instr   (instr),
        .decoded (decodedNow)
    );

    // writeback lands on the same edge as the result reg
    regFile rf0 (
        .clk     (clk),
        .arstN   (arstN),
        .rdAddrA (decodedNow.rsAddr),
        .rdAddrB (decodedNow.rtAddr),
        .rdDataA (rfDataA),
        .rdDataB (rfDataB),
        .wrEn    (resultNext.valid && resultNext.regWrite),
        .wrAddr  (resultNext.destAddr),
        .wrData  (resultNext.data)
    );

    ////////////////////////////////////////
    // forwarding from stage 1
    ////////////////////////////////////////
    // two slots back is already in the file
    assign s1Writes = s1Valid && s1Op.regWrite && (s1Op.destAddr != 5'd0);
    assign fwdA = (s1Writes && (s1Op.destAddr == decodedNow.rsAddr)) ? aluOut : rfDataA;
    assign fwdB = (s1Writes && (s1Op.destAddr == decodedNow.rtAddr)) ? aluOut : rfDataB;

    ////////////////////////////////////////
    // stage 1
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid <= 1'b0;
            s1Op    <= '0;
            s1RsVal <= '0;
            s1RtVal <= '0;
        end else begin
            s1Valid <= instrValid;
            if (instrValid) begin
                s1Op    <= decodedNow;
                s1RsVal <= fwdA;
                s1RtVal <= fwdB;
            end
        end
    end

    // operand B: immediate or rt (shifts take rt too)
    assign aluOpB   = s1Op.useImm ? s1Op.immValue : s1RtVal;
    assign aluShamt = s1Op.useShamt ? s1Op.shamt : 5'd0;

    alu alu0 (
        .aluControl (s1Op.aluOp),
        .opA        (s1RsVal),
        .opB        (aluOpB),
        .shamt      (aluShamt),
        .aluOut     (aluOut)
    );

    ////////////////////////////////////////
    // stage 2 result
    ////////////////////////////////////////
    always_comb begin
        resultNext = '0;
        if (s1Valid) begin
            resultNext.valid    = 1'b1;
            resultNext.illegal  = s1Op.illegal;
            resultNext.regWrite = s1Op.regWrite;      // low for mem and bad ops
            resultNext.destAddr = s1Op.destAddr;
            resultNext.data     = s1Op.illegal ? '0 : aluOut;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
        end else begin
            result <= resultNext; // one-cycle strobe
        end
    end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData
);

    // r0 has no storage
    logic [31:0] regs [1:31];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int idx = 1; idx < 32; idx++) begin
                regs[idx] <= '0;
            end
        end else if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData; // r0 writes dropped
        end
    end

    ////////////////////////////////////////
    // read ports
    ////////////////////////////////////////
    // combinational, no bypass of a same-edge write
    always_comb begin
        if (rdAddrA == 5'd0) begin
            rdDataA = '0;
        end else begin
            rdDataA = regs[rdAddrA];
        end
    end

    always_comb begin
        if (rdAddrB == 5'd0) begin
            rdDataB = '0;
        end else begin
            rdDataB = regs[rdAddrB];
        end
    end

endmodule
